/* id_pkg.sv */
/*
 * Decode stage package
 * Major opcodes, CSR and controller encodings, the fetch-to-decode
 * and decode-to-execute bundles, and the field constants that the
 * RV32 subset decoder compares against
 */

package id_pkg;

  //////////////////////////////
  // Encodings
  //////////////////////////////

  // Major opcodes of the supported subset, instr[6:0]
  typedef enum logic [6:0] {
    OP       = 7'h33,
    OP_IMM   = 7'h13,
    LUI      = 7'h37,
    AUIPC    = 7'h17,
    LOAD     = 7'h03,
    STORE    = 7'h23,
    SYSTEM   = 7'h73,
    MISC_MEM = 7'h0f
  } opcode_e;

  // CSR access kind, READ leaves every CSR unchanged
  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_opcode_e;

  // Controller states, WFI holds the stage until a wake or flush
  typedef enum logic {
    CTRL_RUN = 1'b0,
    CTRL_WFI = 1'b1
  } ctrl_state_e;

  //////////////////////////////
  // Pipeline bundles
  //////////////////////////////

  typedef struct packed {
    logic        instr_valid;
    logic [31:0] pc;
    logic [31:0] instr;
  } if_id_pipe_t;

  // Decoder output, one enable per execute unit plus system flags
  typedef struct packed {
    logic        alu_en;
    logic        mul_en;
    logic        lsu_en;
    logic        lsu_we;
    logic        rf_we;
    csr_opcode_e csr_op;
    logic        ebrk_insn;
    logic        ecall_insn;
    logic        mret_insn;
    logic        dret_insn;
    logic        wfi_insn;
    logic        fencei_insn;
    logic        illegal_insn;
  } decode_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] instr;
    decode_t     dec;
  } id_ex_pipe_t;

  // Requests from the controller to the decode stage
  typedef struct packed {
    logic halt_id;
    logic kill_id;
  } ctrl_fsm_t;

  //////////////////////////////
  // Field constants
  //////////////////////////////

  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;
  // SUB and SRA/SRAI share this funct7
  localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;

  // SYSTEM funct12 values, instr[31:20] with funct3 of zero
  localparam logic [11:0] FUNCT12_ECALL  = 12'h000;
  localparam logic [11:0] FUNCT12_EBREAK = 12'h001;
  localparam logic [11:0] FUNCT12_MRET   = 12'h302;
  localparam logic [11:0] FUNCT12_DRET   = 12'h7b2;
  localparam logic [11:0] FUNCT12_WFI    = 12'h105;

  // Decoder result with every enable and flag inactive
  localparam decode_t DEC_IDLE    = '{csr_op: CSR_OP_READ, default: 1'b0};
  // Illegal result, only the illegal flag is raised
  localparam decode_t DEC_ILLEGAL = '{csr_op: CSR_OP_READ, illegal_insn: 1'b1, default: 1'b0};

endpackage

/* id_decoder.sv */
/*
 * RV32 subset decoder
 * Purely combinational. Turns one instruction word into execute
 * enables, the CSR access kind and the system flags. Anything outside
 * the subset comes out as illegal with every other field inactive
 */

`timescale 1ns/1ps

module id_decoder (
  input  logic [31:0]     instr_i,
  output id_pkg::decode_t dec_o
);
  import id_pkg::*;

  opcode_e     opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [11:0] funct12;
  logic [4:0]  rs1;
  logic [4:0]  rd;
  decode_t     dec;
  logic        illegal;

  // Instruction fields, the opcode cast covers bits [1:0] as well
  assign opcode  = opcode_e'(instr_i[6:0]);
  assign rd      = instr_i[11:7];
  assign funct3  = instr_i[14:12];
  assign rs1     = instr_i[19:15];
  assign funct7  = instr_i[31:25];
  assign funct12 = instr_i[31:20];

  always_comb begin
    dec     = DEC_IDLE;
    illegal = 1'b0;

    case (opcode)
      //////////////////////////////
      // Integer and M extension
      //////////////////////////////
      OP: begin
        if (funct7 == FUNCT7_MULDIV) begin
          dec.mul_en = 1'b1;
          dec.rf_we  = 1'b1;
        end else if ((funct7 == 7'b0) ||
                     ((funct7 == FUNCT7_ALT) && ((funct3 == 3'b000) || (funct3 == 3'b101)))) begin
          dec.alu_en = 1'b1;
          dec.rf_we  = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end

      OP_IMM: begin
        // Shift immediates carry a funct7 of their own
        if ((funct3 == 3'b001) && (funct7 != 7'b0)) begin
          illegal = 1'b1;
        end else if ((funct3 == 3'b101) && (funct7 != 7'b0) && (funct7 != FUNCT7_ALT)) begin
          illegal = 1'b1;
        end else begin
          dec.alu_en = 1'b1;
          dec.rf_we  = 1'b1;
        end
      end

      LUI, AUIPC: begin
        dec.alu_en = 1'b1;
        dec.rf_we  = 1'b1;
      end

      //////////////////////////////
      // Memory access
      //////////////////////////////
      LOAD: begin
        case (funct3)
          3'b000, 3'b001, 3'b010, 3'b100, 3'b101: begin
            dec.lsu_en = 1'b1;
            dec.rf_we  = 1'b1;
          end
          default: illegal = 1'b1;
        endcase
      end

      STORE: begin
        case (funct3)
          3'b000, 3'b001, 3'b010: begin
            dec.lsu_en = 1'b1;
            dec.lsu_we = 1'b1;
          end
          default: illegal = 1'b1;
        endcase
      end

      // Only FENCE.I is supported, plain FENCE is illegal here
      MISC_MEM: begin
        if (funct3 == 3'b001) begin
          dec.fencei_insn = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end

      //////////////////////////////
      // System and CSR
      //////////////////////////////
      SYSTEM: begin
        if (funct3 == 3'b000) begin
          // Privileged instructions need rs1 and rd of zero
          if ((rs1 != 5'd0) || (rd != 5'd0)) begin
            illegal = 1'b1;
          end else begin
            case (funct12)
              FUNCT12_ECALL:  dec.ecall_insn = 1'b1;
              FUNCT12_EBREAK: dec.ebrk_insn  = 1'b1;
              FUNCT12_MRET:   dec.mret_insn  = 1'b1;
              FUNCT12_DRET:   dec.dret_insn  = 1'b1;
              FUNCT12_WFI:    dec.wfi_insn   = 1'b1;
              default:        illegal        = 1'b1;
            endcase
          end
        end else if (funct3 == 3'b100) begin
          illegal = 1'b1;
        end else begin
          // The ALU passes the CSR operand through, the old value goes to rd
          dec.alu_en = 1'b1;
          dec.rf_we  = 1'b1;
          // funct3[2] picks the immediate form and rs1 then holds uimm
          case (funct3[1:0])
            2'b01: dec.csr_op = CSR_OP_WRITE;
            2'b10: begin
              if (rs1 == 5'd0) dec.csr_op = CSR_OP_READ;
              else             dec.csr_op = CSR_OP_SET;
            end
            2'b11: begin
              if (rs1 == 5'd0) dec.csr_op = CSR_OP_READ;
              else             dec.csr_op = CSR_OP_CLEAR;
            end
            default: dec.csr_op = CSR_OP_READ;
          endcase
        end
      end

      default: illegal = 1'b1;
    endcase

    // An illegal word drops every partial decision made above
    if (illegal) begin
      dec = DEC_ILLEGAL;
    end
  end

  assign dec_o = dec;

endmodule

/* id_ctrl_fsm.sv */
/*
 * Decode controller
 * Two-state machine that halts the decode stage after an accepted
 * WFI until wake or flush, and passes flush on as the kill request
 */

`timescale 1ns/1ps

module id_ctrl_fsm (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              wfi_insn_i,
  input  logic              wake_i,
  input  logic              flush_i,
  output id_pkg::ctrl_fsm_t ctrl_fsm_o
);
  import id_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  //////////////////////////////
  // Next state
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      // The WFI itself still goes to execute, halting starts after it
      CTRL_RUN: begin
        if (wfi_insn_i) begin
          state_d = CTRL_WFI;
        end
      end
      // A flush also ends the sleep so the new path can be fetched
      CTRL_WFI: begin
        if (wake_i || flush_i) begin
          state_d = CTRL_RUN;
        end
      end
      default: state_d = CTRL_RUN;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= CTRL_RUN;
    end else begin
      state_q <= state_d;
    end
  end

  // Halt comes from the register, so the wake cycle itself still halts
  assign ctrl_fsm_o.halt_id = (state_q == CTRL_WFI);
  // Kill acts in the flush cycle without a register in between
  assign ctrl_fsm_o.kill_id = flush_i;

endmodule

/* id_stage.sv */
/*
 * Instruction decode stage
 * Decodes the item offered by fetch, applies halt, kill and
 * back-pressure to the ready and valid levels, and holds the result
 * in the ID/EX pipeline register for one item of buffering
 */

`timescale 1ns/1ps

module id_stage (
  input  logic                clk,
  input  logic                rst_n_i,
  input  id_pkg::if_id_pipe_t if_id_pipe_i,
  input  logic                ex_ready_i,
  input  id_pkg::ctrl_fsm_t   ctrl_fsm_i,
  output logic                id_ready_o,
  output logic                id_valid_o,
  output logic                wfi_insn_o,
  output id_pkg::id_ex_pipe_t id_ex_pipe_o
);
  import id_pkg::*;

  decode_t     dec;
  logic        valid_q;
  logic [31:0] pc_q;
  logic [31:0] instr_q;
  decode_t     dec_q;

  id_decoder u_id_decoder (
    .instr_i (if_id_pipe_i.instr),
    .dec_o   (dec)
  );

  //////////////////////////////
  // Ready and valid levels
  //////////////////////////////

  // Kill has priority, the stage then swallows whatever fetch offers
  always_comb begin
    if (ctrl_fsm_i.kill_id) begin
      id_ready_o = 1'b1;
      id_valid_o = 1'b0;
    end else if (ctrl_fsm_i.halt_id) begin
      id_ready_o = 1'b0;
      id_valid_o = 1'b0;
    end else begin
      // Room exists when the register is empty or execute drains it now
      id_ready_o = !valid_q || ex_ready_i;
      id_valid_o = if_id_pipe_i.instr_valid && id_ready_o;
    end
  end

  // Only a WFI that really moves on may put the controller to sleep
  assign wfi_insn_o = dec.wfi_insn && id_valid_o;

  //////////////////////////////
  // ID/EX pipeline register
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (ctrl_fsm_i.kill_id) begin
      valid_q <= 1'b0;
    end else if (id_valid_o) begin
      valid_q <= 1'b1;
    end else if (ex_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // Payload only moves with a new item, so it holds under back-pressure
  always_ff @(posedge clk) begin
    if (id_valid_o) begin
      pc_q    <= if_id_pipe_i.pc;
      instr_q <= if_id_pipe_i.instr;
      dec_q   <= dec;
    end
  end

  assign id_ex_pipe_o = '{valid: valid_q, pc: pc_q, instr: instr_q, dec: dec_q};

endmodule

/* id_top.sv */
/*
 * Decode top level
 * Joins the decode controller and the decode stage
 */

`timescale 1ns/1ps

module id_top (
  input  logic                clk,
  input  logic                rst_n_i,
  input  id_pkg::if_id_pipe_t if_id_pipe_i,
  input  logic                ex_ready_i,
  input  logic                wake_i,
  input  logic                flush_i,
  output logic                id_ready_o,
  output id_pkg::id_ex_pipe_t id_ex_pipe_o
);
  import id_pkg::*;

  ctrl_fsm_t ctrl_fsm;
  logic      wfi_insn;

  id_ctrl_fsm u_id_ctrl_fsm (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .wfi_insn_i (wfi_insn),
    .wake_i     (wake_i),
    .flush_i    (flush_i),
    .ctrl_fsm_o (ctrl_fsm)
  );

  // The valid level has no consumer above the stage
  id_stage u_id_stage (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .if_id_pipe_i (if_id_pipe_i),
    .ex_ready_i   (ex_ready_i),
    .ctrl_fsm_i   (ctrl_fsm),
    .id_ready_o   (id_ready_o),
    .id_valid_o   (),
    .wfi_insn_o   (wfi_insn),
    .id_ex_pipe_o (id_ex_pipe_o)
  );

endmodule

/* id_stage_properties.sv */
/*
 * Decode stage assertions
 * Checks the decoder output and the ready and valid levels of the
 * decode stage under halt and kill
 */

`timescale 1ns/1ps

module id_stage_properties (
  input logic                clk,
  input logic                rst_n_i,
  input id_pkg::if_id_pipe_t if_id_pipe_i,
  input id_pkg::ctrl_fsm_t   ctrl_fsm_i,
  input id_pkg::decode_t     dec_i,
  input logic                id_ready_i,
  input logic                id_valid_i
);
  import id_pkg::*;

  int fail_count = 0;

  a_valid_known: assert property (@(posedge clk) disable iff (!rst_n_i)
    if_id_pipe_i.instr_valid |-> !$isunknown({if_id_pipe_i.pc, if_id_pipe_i.instr}))
    else begin fail_count++; $error("valid instruction carries unknown bits"); end

  // An accepted illegal item never puts the controller to sleep
  a_illegal_quiet: assert property (@(posedge clk) disable iff (!rst_n_i)
    (id_valid_i && dec_i.illegal_insn) |=> !ctrl_fsm_i.halt_id)
    else begin fail_count++; $error("illegal instruction has side effects"); end

  a_halt_blocks: assert property (@(posedge clk) disable iff (!rst_n_i)
    (ctrl_fsm_i.halt_id && !ctrl_fsm_i.kill_id) |-> (!id_ready_i && !id_valid_i))
    else begin fail_count++; $error("halted stage is ready or valid"); end

  a_kill_drops: assert property (@(posedge clk) disable iff (!rst_n_i)
    ctrl_fsm_i.kill_id |-> (id_ready_i && !id_valid_i))
    else begin fail_count++; $error("killed stage is not ready or still valid"); end

endmodule

bind id_stage id_stage_properties u_id_stage_properties (
  .clk          (clk),
  .rst_n_i      (rst_n_i),
  .if_id_pipe_i (if_id_pipe_i),
  .ctrl_fsm_i   (ctrl_fsm_i),
  .dec_i        (dec),
  .id_ready_i   (id_ready_o),
  .id_valid_i   (id_valid_o)
);

/* id_checker.sv */
/*
 * Decode stage checker
 * Watches fetch, execute and flush around the decode top level,
 * predicts each item with its own decode rules and compares the
 * ID/EX output, the ready level and the halt behavior
 */

`timescale 1ns/1ps

module id_checker (
  input  logic                clk,
  input  logic                rst_n_i,
  input  id_pkg::if_id_pipe_t if_id_pipe_i,
  input  logic                ex_ready_i,
  input  logic                wake_i,
  input  logic                flush_i,
  input  logic                id_ready_i,
  input  id_pkg::id_ex_pipe_t id_ex_pipe_i,
  output int                  errors_o,
  output int                  checks_o,
  output int                  pending_o
);
  import id_pkg::*;

  id_ex_pipe_t exp_q [$];
  id_ex_pipe_t held;
  logic        hold_check = 1'b0;
  logic        exp_full = 1'b0;
  logic        exp_halt = 1'b0;
  int          errors = 0;
  int          checks = 0;

  //////////////////////////////
  // Reference decode
  //////////////////////////////

  // Enables follow the unit that executes the word, rf_we follows the enables
  function automatic decode_t ref_decode(input logic [31:0] w);
    decode_t    d;
    logic       ok;
    logic [6:0] op;
    logic [6:0] f7;
    logic [2:0] f3;
    logic [4:0] rs1;
    d = '0;
    ok = 1'b1;
    op = w[6:0];
    f3 = w[14:12];
    f7 = w[31:25];
    rs1 = w[19:15];
    if (op == OP) begin
      if (f7 == FUNCT7_MULDIV) d.mul_en = 1'b1;
      else if ((f7 == 7'd0) || ((f7 == FUNCT7_ALT) && (f3 inside {3'd0, 3'd5}))) d.alu_en = 1'b1;
      else ok = 1'b0;
    end else if (op == OP_IMM) begin
      ok = !((f3 == 3'd1) && (f7 != 7'd0)) &&
           !((f3 == 3'd5) && (f7 != 7'd0) && (f7 != FUNCT7_ALT));
      d.alu_en = 1'b1;
    end else if ((op == LUI) || (op == AUIPC)) begin
      d.alu_en = 1'b1;
    end else if (op == LOAD) begin
      ok = f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
      d.lsu_en = 1'b1;
    end else if (op == STORE) begin
      ok = (f3 < 3'd3);
      d.lsu_en = 1'b1;
      d.lsu_we = 1'b1;
    end else if (op == MISC_MEM) begin
      ok = (f3 == 3'd1);
      d.fencei_insn = 1'b1;
    end else if ((op == SYSTEM) && (f3 == 3'd0)) begin
      ok = (rs1 == 5'd0) && (w[11:7] == 5'd0);
      case (w[31:20])
        FUNCT12_ECALL:  d.ecall_insn = 1'b1;
        FUNCT12_EBREAK: d.ebrk_insn = 1'b1;
        FUNCT12_MRET:   d.mret_insn = 1'b1;
        FUNCT12_DRET:   d.dret_insn = 1'b1;
        FUNCT12_WFI:    d.wfi_insn = 1'b1;
        default:        ok = 1'b0;
      endcase
    end else if ((op == SYSTEM) && (f3 != 3'd4)) begin
      // Set and clear with a zero source only read the CSR
      d.alu_en = 1'b1;
      if (f3[1:0] == 2'd1) d.csr_op = CSR_OP_WRITE;
      else if (rs1 == 5'd0) d.csr_op = CSR_OP_READ;
      else if (f3[1:0] == 2'd2) d.csr_op = CSR_OP_SET;
      else d.csr_op = CSR_OP_CLEAR;
    end else begin
      ok = 1'b0;
    end
    d.rf_we = d.alu_en | d.mul_en | (d.lsu_en & ~d.lsu_we);
    if (!ok) begin
      d = '0;
      d.illegal_insn = 1'b1;
    end
    return d;
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report(input string what);
    errors++;
    $display("error at %0t: %s", $time, what);
  endtask

  //////////////////////////////
  // Cycle monitor
  //////////////////////////////

  // Inputs change on the falling edge, so the rising edge sees settled values
  always @(posedge clk) begin : monitor
    id_ex_pipe_t head;
    id_ex_pipe_t item;
    decode_t     dec_now;
    logic        accept;
    if (!rst_n_i) begin
      compare("id_ex_pipe_o.valid", 32'(id_ex_pipe_i.valid), 32'd0);
      compare("id_ready_o", 32'(id_ready_i), 32'd1);
      exp_q.delete();
      hold_check = 1'b0;
      exp_full = 1'b0;
      exp_halt = 1'b0;
    end else begin
      accept = if_id_pipe_i.instr_valid && id_ready_i && !flush_i;
      dec_now = ref_decode(if_id_pipe_i.instr);

      // Kill before halt before the occupancy rule
      if (flush_i) compare("id_ready_o", 32'(id_ready_i), 32'd1);
      else if (exp_halt) compare("id_ready_o", 32'(id_ready_i), 32'd0);
      else compare("id_ready_o", 32'(id_ready_i), 32'(!exp_full || ex_ready_i));

      // An accepted item shows up exactly one cycle later and leaves once taken
      compare("id_ex_pipe_o.valid", 32'(id_ex_pipe_i.valid), 32'(exp_full));
      if (hold_check && (id_ex_pipe_i !== held)) begin
        errors++;
        $display("[ERROR] %0t id_ex_pipe_o: got %h expected %h", $time, id_ex_pipe_i, held);
      end

      // A flushed register item is dropped without being compared
      if (id_ex_pipe_i.valid && (ex_ready_i || flush_i)) begin
        if (exp_q.size() == 0) begin
          report("id_ex_pipe_o delivered an item that was never accepted");
        end else begin
          head = exp_q.pop_front();
          if (!flush_i) begin
            compare("id_ex_pipe_o.pc", id_ex_pipe_i.pc, head.pc);
            compare("id_ex_pipe_o.instr", id_ex_pipe_i.instr, head.instr);
            compare("id_ex_pipe_o.dec", 32'(id_ex_pipe_i.dec), 32'(head.dec));
          end
        end
      end

      if (accept) begin
        item.valid = 1'b1;
        item.pc = if_id_pipe_i.pc;
        item.instr = if_id_pipe_i.instr;
        item.dec = dec_now;
        exp_q.push_back(item);
      end

      hold_check = id_ex_pipe_i.valid && !ex_ready_i && !flush_i;
      held = id_ex_pipe_i;
      // Occupancy of the ID/EX register as the stage rules predict it
      if (flush_i) exp_full = 1'b0;
      else if (accept) exp_full = 1'b1;
      else if (ex_ready_i) exp_full = 1'b0;
      // Halt starts the cycle after the WFI and ends after the wake cycle
      if (exp_halt) exp_halt = !(wake_i || flush_i);
      else exp_halt = accept && dec_now.wfi_insn;
    end
    errors_o = errors;
    checks_o = checks;
    pending_o = exp_q.size();
  end

endmodule

/* tb_id_top.sv */
/*
 * Decode stage testbench
 * Drives the decode top level from an LFSR and a table of legal
 * encodings, with random back-pressure, flush and fetch gaps, and a
 * wake pulse after each WFI. Comparing lives in the checker module
 */

`timescale 1ns/1ps

module tb_id_top;
  import id_pkg::*;

  logic                clk;
  logic                rst_n;
  if_id_pipe_t         if_id_pipe;
  logic                ex_ready;
  logic                wake;
  logic                flush;
  logic                id_ready;
  id_ex_pipe_t         id_ex_pipe;

  int                  errors;
  int                  checks;
  int                  pending;
  int                  timeouts;
  int                  err_base;
  int                  test_num;
  int                  wait_limit;
  int                  wake_cnt;
  logic                wfi_taken;
  logic [31:0]         lfsr;
  logic [31:0]         next_pc;
  logic [31:0]         wfi_word;

  // One instance of every supported group, CSR forms with rs1 zero included
  logic [31:0] legal_words [0:22] = '{
    32'h003100b3, 32'h403100b3, 32'h023100b3, 32'h023140b3, 32'h00510093,
    32'h40315093, 32'h123450b7, 32'h00001097, 32'h00012083, 32'h00014083,
    32'h00312023, 32'h00310023, 32'h300110f3, 32'h300020f3, 32'h300120f3,
    32'h300130f3, 32'h3002d0f3, 32'h300070f3, 32'h00000073, 32'h00100073,
    32'h30200073, 32'h7b200073, 32'h0000100f
  };

  // FENCE, AMO, bad funct3 and funct7, SRET, rd set on ECALL, compressed
  logic [31:0] illegal_words [0:9] = '{
    32'h0ff0000f, 32'h0031202f, 32'h00314023, 32'h000000f3, 32'h403110b3,
    32'h40311093, 32'h10200073, 32'h00013083, 32'h300140f3, 32'h00004501
  };

  id_top u_id_top (
    .clk          (clk),
    .rst_n_i      (rst_n),
    .if_id_pipe_i (if_id_pipe),
    .ex_ready_i   (ex_ready),
    .wake_i       (wake),
    .flush_i      (flush),
    .id_ready_o   (id_ready),
    .id_ex_pipe_o (id_ex_pipe)
  );

  id_checker u_id_checker (
    .clk          (clk),
    .rst_n_i      (rst_n),
    .if_id_pipe_i (if_id_pipe),
    .ex_ready_i   (ex_ready),
    .wake_i       (wake),
    .flush_i      (flush),
    .id_ready_i   (id_ready),
    .id_ex_pipe_i (id_ex_pipe),
    .errors_o     (errors),
    .checks_o     (checks),
    .pending_o    (pending)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////
  // Random source
  //////////////////////////////

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = 32'd0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  //////////////////////////////
  // Wake pulse after each WFI
  //////////////////////////////

  always @(posedge clk) begin
    wfi_taken <= rst_n && if_id_pipe.instr_valid && id_ready && !flush &&
                 (if_id_pipe.instr == wfi_word);
  end

  // The pulse comes five cycles after the WFI left fetch
  initial begin
    wake = 1'b0;
    wake_cnt = 0;
    forever begin
      @(negedge clk);
      if (wfi_taken) begin
        wake_cnt = 6;
      end else if (wake_cnt != 0) begin
        wake_cnt = wake_cnt - 1;
      end
      wake = (wake_cnt == 1);
    end
  end

  //////////////////////////////
  // Fetch and execute driving
  //////////////////////////////

  // Offers one word until it is taken, with random gaps, stalls and flushes
  task automatic send_item(input logic [31:0] word, input logic [3:0] bp_level,
                           input logic [4:0] fl_level);
    logic [31:0] r;
    logic        taken;
    int          waited;
    taken = 1'b0;
    waited = 0;
    while (!taken && (waited < wait_limit)) begin
      @(negedge clk);
      draw_bits(11, r);
      if_id_pipe.instr_valid = (r[1:0] != 2'b00);
      if_id_pipe.pc = next_pc;
      if_id_pipe.instr = word;
      ex_ready = (r[5:2] >= bp_level);
      flush = (r[10:6] < fl_level);
      @(posedge clk);
      taken = if_id_pipe.instr_valid && id_ready;
      waited++;
    end
    if (!taken) begin
      timeouts++;
      $display("timeout: item at pc %h was never accepted", next_pc);
    end
    next_pc = next_pc + 32'd4;
  endtask

  // Half the items come from the legal table, the rest are raw LFSR words
  task automatic send_mixed(input logic [3:0] bp_level, input logic [4:0] fl_level);
    logic [31:0] r;
    logic [31:0] word;
    draw_bits(1, r);
    if (r[0]) begin
      draw_bits(5, r);
      word = legal_words[r[4:0] % 5'd23];
    end else begin
      draw_bits(32, word);
    end
    send_item(word, bp_level, fl_level);
  endtask

  // Empties the pipeline register so each test ends with nothing in flight
  task automatic drain();
    int waited;
    waited = 0;
    @(negedge clk);
    if_id_pipe.instr_valid = 1'b0;
    ex_ready = 1'b1;
    flush = 1'b0;
    while (((pending != 0) || id_ex_pipe.valid) && (waited < wait_limit)) begin
      @(negedge clk);
      waited++;
    end
    if (waited >= wait_limit) begin
      timeouts++;
      $display("timeout: items were still in flight at the end of a test");
    end
  endtask

  task automatic end_test(input string name);
    int n;
    drain();
    n = errors + timeouts - err_base;
    test_num++;
    $display("test %0d %s: %s, %0d errors", test_num, name, (n == 0) ? "ok" : "failed", n);
    err_base = errors + timeouts;
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    logic [31:0] r;
    int          prop_fails;
    if_id_pipe = '0;
    ex_ready = 1'b1;
    flush = 1'b0;
    rst_n = 1'b0;
    lfsr = 32'hb2c5d16f;
    next_pc = 32'h8000_0000;
    wfi_word = 32'h10500073;
    wait_limit = 200;
    timeouts = 0;
    err_base = 0;
    test_num = 0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    end_test("reset");

    for (int k = 0; k < 23; k++) begin
      send_item(legal_words[k[4:0]], 4'd0, 5'd0);
    end
    end_test("legal encodings");

    for (int k = 0; k < 10; k++) begin
      send_item(illegal_words[k[3:0]], 4'd2, 5'd0);
    end
    for (int k = 0; k < 40; k++) begin
      draw_bits(32, r);
      send_item(r, 4'd2, 5'd0);
    end
    end_test("illegal words");

    for (int k = 0; k < 60; k++) begin
      send_mixed(4'd10, 5'd0);
    end
    end_test("back-pressure");

    // Flush stays off so that only the wake pulse can end the halt
    for (int n = 0; n < 2; n++) begin
      for (int k = 0; k < 4; k++) begin
        send_mixed(4'd4, 5'd0);
      end
      send_item(wfi_word, 4'd4, 5'd0);
      for (int k = 0; k < 8; k++) begin
        send_mixed(4'd4, 5'd0);
      end
    end
    end_test("wfi and wake");

    for (int k = 0; k < 60; k++) begin
      send_mixed(4'd6, 5'd4);
    end
    end_test("flush");

    prop_fails = u_id_top.u_id_stage.u_id_stage_properties.fail_count;
    $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
             checks, errors, timeouts, prop_fails);
    if ((errors == 0) && (timeouts == 0) && (prop_fails == 0)) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* flist.f */
id_pkg.sv
id_decoder.sv
id_ctrl_fsm.sv
id_stage.sv
id_top.sv
id_stage_properties.sv
id_checker.sv
tb_id_top.sv

/* Makefile */
# Verilator build and run for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_id_top
RTL_TOP   ?= id_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL CHECKS PASSED
VFLAGS    ?= --binary --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

# The log decides, since the simulator exit status alone is not enough
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
